// ==== compile.f ====
+incdir+source
source/mailbox_pkg.sv
source/apb_pkg.sv
source/mailbox_sync.sv
source/mailbox_fifo.sv
source/toggle_mailbox_bridge.sv
source/mailbox_apb_regs.sv
source/mailbox_top.sv
verif/mailbox_tb.sv

// ==== verif/mailbox_tb.sv ====
/*
 * Mailbox testbench
 *   Clock, reset and APB host driver
 *   Remote agent model for the inbound and outbound toggle links
 *   Reference queues, STATUS reference function and compare process
 */

`timescale 1ns/1ps
`include "mailbox_defines.svh"

module mailbox_tb;

	logic               clk;
	logic               rst_n;
	apb_pkg::apb_req_t  apb_req;
	apb_pkg::apb_rsp_t  apb_rsp;
	mailbox_pkg::link_t in_link;
	logic               in_ack;
	mailbox_pkg::link_t out_link;
	logic               out_ack;

	integer seed = 27;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     errors_at_start;
	int     rcv_count = 0;
	string  test_name;
	bit     responder_paused = 1'b0;

	// Reference queues
	logic [`MBX_DATA_W-1:0] tx_q[$];
	logic [`MBX_DATA_W-1:0] rx_q[$];
	logic [`MBX_DATA_W-1:0] remote_q[$];

	mailbox_top dut0 (
		.rvx_port_12 (clk),
		.rvx_port_03 (rst_n),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.in_link     (in_link),
		.in_ack      (in_ack),
		.out_link    (out_link),
		.out_ack     (out_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// STATUS as the register map defines it
	function automatic logic [31:0] expected_status(input int tx_n, input int rx_n);
		logic [31:0] word;
		word        = '0;
		word[5:0]   = tx_n[5:0];
		word[13:8]  = rx_n[5:0];
		word[16]    = (tx_n == `MBX_FIFO_DEPTH);
		word[17]    = (rx_n == 0);
		return word;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test;
		if (errors == errors_at_start)
			$display("Test %s: passed", test_name);
		else
		begin
			$display("Test %s: failed", test_name);
			tests_failed++;
		end
	endtask

	// **************************************************
	// APB host driver
	// **************************************************

	task automatic apb_access(input logic write, input logic [`MBX_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		// No wait states, the access phase completes in its first cycle
		#2;
		check_value("pready", 1, apb_rsp.pready);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge clk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	// **************************************************
	// Remote agent
	// **************************************************

	// Data settles one cycle before the toggle flips
	task automatic offer_inbound(input logic [31:0] word);
		@(negedge clk);
		in_link.data = word;
		@(negedge clk);
		in_link.toggle = ~in_link.toggle;
		rx_q.push_back(word);
	endtask

	task automatic wait_in_ack(input int max_cycles, output bit acked);
		acked = 1'b0;
		for (int i = 0; i < max_cycles && !acked; i++)
		begin
			@(negedge clk);
			if (in_ack == in_link.toggle)
				acked = 1'b1;
		end
	endtask

	task automatic send_inbound(input logic [31:0] word);
		bit acked;
		offer_inbound(word);
		wait_in_ack(50, acked);
		if (!acked)
		begin
			$display("Timeout at %0t ns: in_ack never answered inbound word %h", $time, word);
			errors++;
		end
	endtask

	task automatic wait_tx_drain(input int max_cycles);
		int cycles;
		cycles = 0;
		while (tx_q.size() != 0 && cycles < max_cycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (tx_q.size() != 0)
		begin
			$display("Timeout at %0t ns: %0d outbound words never reached the remote side",
				$time, tx_q.size());
			errors++;
		end
	endtask

	// Outbound responder that acknowledges after 1 to 6 cycles
	initial
	begin
		int delay;
		forever
		begin
			@(negedge clk);
			if (!responder_paused && rst_n && out_link.toggle != out_ack)
			begin
				delay = 1 + ({$random(seed)} % 6);
				repeat (delay) @(negedge clk);
				remote_q.push_back(out_link.data);
				out_ack = out_link.toggle;
			end
		end
	end

	// Compare process for words seen by the remote side
	initial
	begin
		logic [31:0] got;
		logic [31:0] exp;
		forever
		begin
			@(posedge clk);
			while (remote_q.size() > 0)
			begin
				got = remote_q.pop_front();
				rcv_count++;
				if (tx_q.size() == 0)
				begin
					$display("Remote side got word %h at %0t ns with none outstanding",
						got, $time);
					errors++;
				end
				else
				begin
					exp = tx_q.pop_front();
					check_value("out_link.data", exp, got);
				end
			end
		end
	end

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] word;
		logic        err;
		bit          acked;
		int          rcv_before;

		rst_n   = 1'b0;
		apb_req = '0;
		in_link = '0;
		out_ack = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		begin_test("reset state");
		apb_access(1'b0, `MBX_ADDR_STATUS, '0, rdata, err);
		check_value("STATUS", expected_status(0, 0), rdata);
		check_value("in_ack", 0, in_ack);
		check_value("out_link.toggle", 0, out_link.toggle);
		end_test();

		begin_test("outbound random words");
		for (int i = 0; i < 20; i++)
		begin
			word = $random(seed);
			tx_q.push_back(word);
			apb_access(1'b1, `MBX_ADDR_TX, word, rdata, err);
			check_value("pslverr", 0, err);
		end
		wait_tx_drain(1000);
		end_test();

		begin_test("inbound words");
		for (int i = 0; i < 10; i++)
			send_inbound($random(seed));
		apb_access(1'b0, `MBX_ADDR_STATUS, '0, rdata, err);
		check_value("STATUS", expected_status(0, 10), rdata);
		for (int i = 0; i < 10; i++)
		begin
			apb_access(1'b0, `MBX_ADDR_RX, '0, rdata, err);
			check_value("RX_DATA", rx_q.pop_front(), rdata);
			check_value("pslverr", 0, err);
		end
		end_test();

		begin_test("bus errors");
		apb_access(1'b0, `MBX_ADDR_RX, '0, rdata, err);
		check_value("pslverr", 1, err);
		check_value("prdata", 0, rdata);
		apb_access(1'b0, 4'hC, '0, rdata, err);
		check_value("pslverr", 1, err);
		check_value("prdata", 0, rdata);
		apb_access(1'b1, `MBX_ADDR_STATUS, 32'h1234_5678, rdata, err);
		check_value("pslverr", 1, err);
		check_value("prdata", 0, rdata);
		end_test();

		begin_test("inbound back-pressure");
		for (int i = 0; i < `MBX_FIFO_DEPTH; i++)
			send_inbound($random(seed));
		offer_inbound($random(seed));
		wait_in_ack(40, acked);
		if (acked)
		begin
			$display("in_ack answered at %0t ns while the inbound FIFO was full", $time);
			errors++;
		end
		apb_access(1'b0, `MBX_ADDR_RX, '0, rdata, err);
		check_value("RX_DATA", rx_q.pop_front(), rdata);
		check_value("pslverr", 0, err);
		wait_in_ack(20, acked);
		if (!acked)
		begin
			$display("Timeout at %0t ns: held inbound word not taken after a read", $time);
			errors++;
		end
		for (int i = 0; i < `MBX_FIFO_DEPTH; i++)
		begin
			apb_access(1'b0, `MBX_ADDR_RX, '0, rdata, err);
			check_value("RX_DATA", rx_q.pop_front(), rdata);
			check_value("pslverr", 0, err);
		end
		end_test();

		begin_test("outbound back-pressure");
		responder_paused = 1'b1;
		rcv_before = rcv_count;
		for (int i = 0; i < `MBX_FIFO_DEPTH; i++)
		begin
			word = $random(seed);
			tx_q.push_back(word);
			apb_access(1'b1, `MBX_ADDR_TX, word, rdata, err);
			check_value("pslverr", 0, err);
		end
		apb_access(1'b1, `MBX_ADDR_TX, 32'hDEAD_BEEF, rdata, err);
		check_value("pslverr", 1, err);
		apb_access(1'b0, `MBX_ADDR_STATUS, '0, rdata, err);
		check_value("STATUS", expected_status(`MBX_FIFO_DEPTH, 0), rdata);
		responder_paused = 1'b0;
		wait_tx_drain(2000);
		// A rejected write must never follow the accepted words out
		repeat (40) @(negedge clk);
		apb_access(1'b0, `MBX_ADDR_STATUS, '0, rdata, err);
		check_value("STATUS", expected_status(0, 0), rdata);
		check_value("received count", `MBX_FIFO_DEPTH, rcv_count - rcv_before);
		end_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Overall run limit
	initial
	begin
		#500000;
		$display("Run limit reached at %0t ns, the test sequence did not finish", $time);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== source/mailbox_top.sv ====
/*
 * Mailbox top level
 *   APB register block and toggle bridge to the remote agent
 */

`timescale 1ns/1ps
`include "mailbox_defines.svh"

module mailbox_top (
	input  logic               rvx_port_12,
	input  logic               rvx_port_03,
	input  apb_pkg::apb_req_t  apb_req,
	output apb_pkg::apb_rsp_t  apb_rsp,
	input  mailbox_pkg::link_t in_link,
	output logic               in_ack,
	output mailbox_pkg::link_t out_link,
	input  logic               out_ack
);

	logic                   tx_push;
	logic [`MBX_DATA_W-1:0] tx_data;
	logic [`MBX_CNT_W-1:0]  tx_count;
	logic                   tx_full;
	logic                   rx_pop;
	logic [`MBX_DATA_W-1:0] rx_data;
	logic [`MBX_CNT_W-1:0]  rx_count;
	logic                   rx_empty;

	mailbox_apb_regs u_regs (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.tx_push     (tx_push),
		.tx_data     (tx_data),
		.tx_count    (tx_count),
		.tx_full     (tx_full),
		.rx_pop      (rx_pop),
		.rx_data     (rx_data),
		.rx_count    (rx_count),
		.rx_empty    (rx_empty)
	);

	toggle_mailbox_bridge u_bridge (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.in_link     (in_link),
		.in_ack      (in_ack),
		.out_link    (out_link),
		.out_ack     (out_ack),
		.tx_push     (tx_push),
		.tx_data     (tx_data),
		.tx_count    (tx_count),
		.tx_full     (tx_full),
		.rx_pop      (rx_pop),
		.rx_data     (rx_data),
		.rx_count    (rx_count),
		.rx_empty    (rx_empty)
	);

endmodule

// ==== source/mailbox_apb_regs.sv ====
/*
 * APB slave for the mailbox
 *   TX_DATA write pushes, RX_DATA read pops, STATUS read reports levels
 *   No wait states, errors on full, empty and bad accesses
 */

`timescale 1ns/1ps
`include "mailbox_defines.svh"

module mailbox_apb_regs (
	input  logic                   rvx_port_12,
	input  logic                   rvx_port_03,
	input  apb_pkg::apb_req_t      apb_req,
	output apb_pkg::apb_rsp_t      apb_rsp,
	output logic                   tx_push,
	output logic [`MBX_DATA_W-1:0] tx_data,
	input  logic [`MBX_CNT_W-1:0]  tx_count,
	input  logic                   tx_full,
	output logic                   rx_pop,
	input  logic [`MBX_DATA_W-1:0] rx_data,
	input  logic [`MBX_CNT_W-1:0]  rx_count,
	input  logic                   rx_empty
);

	apb_pkg::reg_sel_e        reg_sel;
	mailbox_pkg::mbx_status_t status;
	logic                     setup_q;
	logic                     access;
	logic                     req_err;
	logic [`MBX_DATA_W-1:0]   rd_data;

	// Access phase counts only when it follows a setup phase
	always_ff @(posedge rvx_port_12 or negedge rvx_port_03)
	begin
		if (!rvx_port_03)
			setup_q <= 1'b0;
		else
			setup_q <= apb_req.psel & ~apb_req.penable;
	end

	assign access = apb_req.psel & apb_req.penable & setup_q;

	always_comb
	begin
		case (apb_req.paddr)
			`MBX_ADDR_TX:     reg_sel = apb_pkg::SEL_TX;
			`MBX_ADDR_RX:     reg_sel = apb_pkg::SEL_RX;
			`MBX_ADDR_STATUS: reg_sel = apb_pkg::SEL_STATUS;
			default:          reg_sel = apb_pkg::SEL_NONE;
		endcase
	end

	always_comb
	begin
		status          = '0;
		status.tx_count = tx_count;
		status.rx_count = rx_count;
		status.tx_full  = tx_full;
		status.rx_empty = rx_empty;
	end

	// TX_DATA is write only, RX_DATA and STATUS are read only
	always_comb
	begin
		req_err = 1'b1;
		rd_data = '0;
		case (reg_sel)
			apb_pkg::SEL_TX:
				req_err = ~apb_req.pwrite | tx_full;
			apb_pkg::SEL_RX:
			begin
				req_err = apb_req.pwrite | rx_empty;
				rd_data = rx_data;
			end
			apb_pkg::SEL_STATUS:
			begin
				req_err = apb_req.pwrite;
				rd_data = status;
			end
			default:
				req_err = 1'b1;
		endcase
	end

	assign tx_push = access & apb_req.pwrite & (reg_sel == apb_pkg::SEL_TX) & ~req_err;
	assign tx_data = apb_req.pwdata;
	assign rx_pop  = access & ~apb_req.pwrite & (reg_sel == apb_pkg::SEL_RX) & ~req_err;

	// Failed reads return zero
	assign apb_rsp.prdata  = (access & ~apb_req.pwrite & ~req_err) ? rd_data : '0;
	assign apb_rsp.pready  = apb_req.psel & apb_req.penable;
	assign apb_rsp.pslverr = access & req_err;

endmodule

// ==== source/toggle_mailbox_bridge.sv ====
/*
 * Toggle-handshake mailbox bridge
 *   Inbound: synchronized remote toggle, three-sample filter, commit to FIFO
 *   Outbound: offer FIFO head by toggling, pop on synchronized acknowledge
 */

`timescale 1ns/1ps
`include "mailbox_defines.svh"

module toggle_mailbox_bridge (
	input  logic                   rvx_port_12,
	input  logic                   rvx_port_03,
	input  mailbox_pkg::link_t     in_link,
	output logic                   in_ack,
	output mailbox_pkg::link_t     out_link,
	input  logic                   out_ack,
	input  logic                   tx_push,
	input  logic [`MBX_DATA_W-1:0] tx_data,
	output logic [`MBX_CNT_W-1:0]  tx_count,
	output logic                   tx_full,
	input  logic                   rx_pop,
	output logic [`MBX_DATA_W-1:0] rx_data,
	output logic [`MBX_CNT_W-1:0]  rx_count,
	output logic                   rx_empty
);

	mailbox_pkg::link_t      in_sync;
	logic                    out_ack_sync;
	mailbox_pkg::in_state_e  in_state;
	mailbox_pkg::out_state_e out_state;
	logic                    out_toggle;
	logic                    in_pending;
	logic                    rx_full;
	logic                    rx_push;
	logic                    tx_empty;
	logic                    tx_pop;
	logic [`MBX_DATA_W-1:0]  tx_head;

	mailbox_sync #(.WIDTH($bits(mailbox_pkg::link_t))) u_in_sync (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.async_value (in_link),
		.sync_value  (in_sync)
	);

	mailbox_sync #(.WIDTH(1)) u_ack_sync (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.async_value (out_ack),
		.sync_value  (out_ack_sync)
	);

	// **************************************************
	// Inbound path
	// **************************************************

	// A word is waiting while the remote toggle differs from our ack
	assign in_pending = (in_sync.toggle != in_ack);
	assign rx_push    = (in_state == mailbox_pkg::IN_COMMIT) & ~rx_full;

	always_ff @(posedge rvx_port_12 or negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			in_state <= mailbox_pkg::IN_IDLE;
			in_ack   <= 1'b0;
		end
		else
		begin
			case (in_state)
				mailbox_pkg::IN_IDLE:
					if (in_pending)
						in_state <= mailbox_pkg::IN_SEEN1;
				mailbox_pkg::IN_SEEN1:
					in_state <= in_pending ? mailbox_pkg::IN_SEEN2 : mailbox_pkg::IN_IDLE;
				mailbox_pkg::IN_SEEN2:
					in_state <= in_pending ? mailbox_pkg::IN_COMMIT : mailbox_pkg::IN_IDLE;
				mailbox_pkg::IN_COMMIT:
					// Hold here while the FIFO is full
					if (rx_push)
					begin
						in_state <= mailbox_pkg::IN_IDLE;
						in_ack   <= ~in_ack;
					end
				default:
					in_state <= mailbox_pkg::IN_IDLE;
			endcase
		end
	end

	mailbox_fifo #(
		.WIDTH (`MBX_DATA_W),
		.DEPTH (`MBX_FIFO_DEPTH),
		.CNT_W (`MBX_CNT_W)
	) u_rx_fifo (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.push        (rx_push),
		.push_data   (in_sync.data),
		.pop         (rx_pop),
		.head        (rx_data),
		.full        (rx_full),
		.empty       (rx_empty),
		.count       (rx_count)
	);

	// **************************************************
	// Outbound path
	// **************************************************

	mailbox_fifo #(
		.WIDTH (`MBX_DATA_W),
		.DEPTH (`MBX_FIFO_DEPTH),
		.CNT_W (`MBX_CNT_W)
	) u_tx_fifo (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_03 (rvx_port_03),
		.push        (tx_push),
		.push_data   (tx_data),
		.pop         (tx_pop),
		.head        (tx_head),
		.full        (tx_full),
		.empty       (tx_empty),
		.count       (tx_count)
	);

	// Remote has taken the word once its ack catches up with our toggle
	assign tx_pop = (out_state == mailbox_pkg::OUT_WAIT_ACK) & (out_ack_sync == out_toggle);

	always_ff @(posedge rvx_port_12 or negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			out_state  <= mailbox_pkg::OUT_IDLE;
			out_toggle <= 1'b0;
		end
		else
		begin
			case (out_state)
				mailbox_pkg::OUT_IDLE:
					if (!tx_empty)
					begin
						out_state  <= mailbox_pkg::OUT_WAIT_ACK;
						out_toggle <= ~out_toggle;
					end
				mailbox_pkg::OUT_WAIT_ACK:
					if (tx_pop)
						out_state <= mailbox_pkg::OUT_IDLE;
				default:
					out_state <= mailbox_pkg::OUT_IDLE;
			endcase
		end
	end

	// Data always follows the FIFO head, stable until popped
	assign out_link = {out_toggle, tx_head};

endmodule

// ==== source/mailbox_fifo.sv ====
/*
 * Synchronous circular-buffer FIFO
 *   Combinational head, occupancy count, full and empty
 *   Push when full and pop when empty are dropped
 */

`timescale 1ns/1ps

module mailbox_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 63,
	parameter int CNT_W = 6
) (
	input  logic             rvx_port_12,
	input  logic             rvx_port_03,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] head,
	output logic             full,
	output logic             empty,
	output logic [CNT_W-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	// Pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge rvx_port_12 or negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge rvx_port_12)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	assign head  = mem[rd_ptr];
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

endmodule

// ==== source/mailbox_sync.sv ====
/*
 * Two-stage synchronizer for signals entering the local clock domain
 */

`timescale 1ns/1ps

module mailbox_sync #(
	parameter int WIDTH = 1
) (
	input  logic             rvx_port_12,
	input  logic             rvx_port_03,
	input  logic [WIDTH-1:0] async_value,
	output logic [WIDTH-1:0] sync_value
);

	logic [WIDTH-1:0] meta;

	always_ff @(posedge rvx_port_12 or negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			meta       <= '0;
			sync_value <= '0;
		end
		else
		begin
			meta       <= async_value;
			sync_value <= meta;
		end
	end

endmodule

// ==== source/apb_pkg.sv ====
/*
 * APB host bus types
 *   apb_req_t   request from the host
 *   apb_rsp_t   response from the slave
 *   reg_sel_e   decoded register select
 */

`include "mailbox_defines.svh"

package apb_pkg;

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`MBX_ADDR_W-1:0] paddr;
		logic [`MBX_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`MBX_DATA_W-1:0] prdata;
		logic                   pready;
		logic                   pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		SEL_TX     = 2'd0,
		SEL_RX     = 2'd1,
		SEL_STATUS = 2'd2,
		SEL_NONE   = 2'd3
	} reg_sel_e;

endpackage

// ==== source/mailbox_pkg.sv ====
/*
 * Mailbox types
 *   link_t        toggle plus data word crossing to the remote side
 *   in_state_e    inbound three-sample filter states
 *   out_state_e   outbound offer / wait states
 *   mbx_status_t  STATUS register layout
 */

`include "mailbox_defines.svh"

package mailbox_pkg;

	typedef struct packed {
		logic                   toggle;
		logic [`MBX_DATA_W-1:0] data;
	} link_t;

	typedef enum logic [1:0] {
		IN_IDLE   = 2'd0,
		IN_SEEN1  = 2'd1,
		IN_SEEN2  = 2'd2,
		IN_COMMIT = 2'd3
	} in_state_e;

	typedef enum logic {
		OUT_IDLE     = 1'b0,
		OUT_WAIT_ACK = 1'b1
	} out_state_e;

	// Counts are byte aligned, flags sit in the third byte
	typedef struct packed {
		logic [13:0]              rsvd_hi;
		logic                     rx_empty;
		logic                     tx_full;
		logic [7-`MBX_CNT_W:0]    rsvd_rx;
		logic [`MBX_CNT_W-1:0]    rx_count;
		logic [7-`MBX_CNT_W:0]    rsvd_tx;
		logic [`MBX_CNT_W-1:0]    tx_count;
	} mbx_status_t;

endpackage

// ==== source/mailbox_defines.svh ====
/*
 * Mailbox widths, FIFO sizing and APB register offsets
 */

`ifndef MAILBOX_DEFINES_SVH
`define MAILBOX_DEFINES_SVH

// Word width on both the toggle links and the APB data bus
`define MBX_DATA_W      32
`define MBX_FIFO_DEPTH  63
`define MBX_CNT_W       6

// APB byte offsets
`define MBX_ADDR_W      4
`define MBX_ADDR_TX     4'h0
`define MBX_ADDR_RX     4'h4
`define MBX_ADDR_STATUS 4'h8

`endif
